//--- fetch_queue.f
verilog/fetch_pkg.sv
verilog/fifo_generator.sv
verilog/fetch_ctrl.sv
verilog/fetch_buffer.sv
verilog/fetch_frontend.sv
bench/tb_fetch_frontend.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the fetch queue testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
    --top-module tb_fetch_frontend \
    -Mdir obj_dir \
    -f fetch_queue.f

./obj_dir/Vtb_fetch_frontend > sim.log 2>&1
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

//--- bench/tb_fetch_frontend.sv
module tb_fetch_frontend import fetch_pkg::*; ();

    localparam int    BUF_DEPTH    = 8;
    localparam int    NUM_ROWS     = 11;
    localparam int    READY_ALWAYS = 0;
    localparam int    READY_NEVER  = 1;
    localparam int    READY_RANDOM = 2;
    localparam word_t CACHE_KEY    = 32'h1357_9bdf;    // Cache words are the address XOR this key

    typedef struct packed {
        addr_t      pc;
        excp_code_t excp;
        priv_t      priv;
    } exp_entry_t;

    typedef struct {
        int    cycles;
        int    mode;
        logic  redir;
        addr_t target;
        priv_t priv;
    } row_t;

    logic       clk;
    logic       arst_n;
    logic       redirect;
    addr_t      redirect_pc;
    logic       decode_ready;
    priv_t      priv_level;
    logic       icache_req;
    addr_t      icache_pc;
    logic       icache_resp_valid = 1'b0;
    word_t      icache_inst0 = '0;
    word_t      icache_inst1 = '0;
    logic       fifo_valid;
    word_t      fifo_inst0;
    word_t      fifo_inst1;
    addr_t      fifo_pc;
    addr_t      fifo_pc_add;
    addr_t      fifo_pc_next;
    addr_t      fifo_badv;
    excp_code_t fifo_exception;
    priv_t      fifo_priv_flag;

    exp_entry_t  sb_q[$];                              // Entries expected on the decode port
    row_t        rows [NUM_ROWS];
    addr_t       exp_fetch;                            // Next fetch address by the sequential rule
    addr_t       resp_addr;
    addr_t       bad_target;
    addr_t       cache_addr;
    logic        cache_req = 1'b0;
    logic        resp_pend;
    logic        flush_now;                            // The coming edge is the flush edge
    logic        adef_now;
    logic        halted;
    logic        first_cycle;
    logic        drained = 1'b0;
    int          used;                                 // Credits spent and not yet returned
    int          value_errors = 0;
    int          other_errors = 0;
    int          full_cycles = 0;
    int          adef_pops = 0;
    int unsigned rng = 97243;

    fetch_frontend #(
        .BUF_DEPTH     (BUF_DEPTH),
        .LOG_BUF_DEPTH (3)
    ) u_fetch_frontend (.*);

    function automatic int unsigned lcg_next(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0t: %s expected 0x%h, got 0x%h", $time, name, exp, got);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0t: %s expected 0x%h, got 0x%h", $time, name, exp, got);
        end
    endtask

    task automatic check_excp(input string name, input excp_code_t got, input excp_code_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0t: %s expected 0x%h, got 0x%h", $time, name, exp, got);
        end
    endtask

    task automatic check_priv(input string name, input priv_t got, input priv_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0t: %s expected 0x%h, got 0x%h", $time, name, exp, got);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0t: %s expected 0x%h, got 0x%h", $time, name, exp, got);
        end
    endtask

    // An entry with an exception never touched the cache and carries no-ops
    task automatic compare_pop(input exp_entry_t e);
        logic ok;
        ok = e.excp == EXCP_NONE;
        check_word("fifo_inst0", fifo_inst0, ok ? (e.pc ^ CACHE_KEY) : INST_NOP);
        check_word("fifo_inst1", fifo_inst1, ok ? ((e.pc + 32'd4) ^ CACHE_KEY) : INST_NOP);
        check_addr("fifo_pc", fifo_pc, e.pc);
        check_addr("fifo_pc_add", fifo_pc_add, e.pc + 32'd4);
        check_addr("fifo_pc_next", fifo_pc_next, e.pc + 32'd8);
        check_addr("fifo_badv", fifo_badv, e.pc);
        check_excp("fifo_exception", fifo_exception, e.excp);
        check_priv("fifo_priv_flag", fifo_priv_flag, e.priv);
    endtask

    task automatic set_row(input int idx, input int cycles, input int mode, input logic redir,
                           input addr_t target, input priv_t priv);
        rows[idx] = '{cycles, mode, redir, target, priv};
    endtask

    task automatic apply_row(input row_t row);
        for (int c = 0; c < row.cycles; c++) begin
            @(posedge clk);
            redirect   <= (c == 0) && row.redir;       // One-cycle pulse at the start of a row
            priv_level <= row.priv;
            if (c == 0 && row.redir) begin
                redirect_pc <= row.target;
            end
            rng = lcg_next(rng);
            case (row.mode)
                READY_ALWAYS: decode_ready <= 1'b1;
                READY_NEVER:  decode_ready <= 1'b0;
                default:      decode_ready <= rng[16];
            endcase
        end
    endtask

    task automatic wait_queue_drained(output logic timed_out);
        timed_out = 1'b1;
        for (int n = 0; n < 200; n++) begin
            @(posedge clk);
            if (drained) begin
                timed_out = 1'b0;
                break;
            end
        end
    endtask

    // Cache answers on the edge after the request it saw
    always @(posedge clk) begin
        icache_resp_valid <= cache_req;
        if (cache_req) begin
            icache_inst0 <= cache_addr ^ CACHE_KEY;
            icache_inst1 <= (cache_addr + 32'd4) ^ CACHE_KEY;
        end
    end

    // Every value seen at the falling edge is what the coming rising edge will sample
    always @(negedge clk) begin
        if (!arst_n) begin
            check_flag("icache_req", icache_req, 1'b0);
            check_flag("fifo_valid", fifo_valid, 1'b0);
            sb_q.delete();
            exp_fetch   = PC_RESET;
            cache_req   = 1'b0;
            resp_pend   = 1'b0;
            flush_now   = 1'b0;
            adef_now    = 1'b0;
            halted      = 1'b0;
            first_cycle = 1'b1;
            used        = 0;
        end else begin
            if (flush_now) begin
                sb_q.delete();                         // Everything pushed before the flush is gone
            end
            if (first_cycle) begin
                check_flag("icache_req", icache_req, 1'b0);
            end
            first_cycle = 1'b0;
            check_flag("fifo_valid", fifo_valid, sb_q.size() != 0);
            if (!fifo_valid) begin
                check_word("fifo_inst0", fifo_inst0, INST_NOP);
                check_word("fifo_inst1", fifo_inst1, INST_NOP);
                check_addr("fifo_pc", fifo_pc, PC_RESET);
                check_addr("fifo_pc_add", fifo_pc_add, PC_RESET + 32'd4);
                check_addr("fifo_pc_next", fifo_pc_next, PC_RESET + 32'd8);
                check_addr("fifo_badv", fifo_badv, PC_RESET);
                check_excp("fifo_exception", fifo_exception, EXCP_NONE);
                check_priv("fifo_priv_flag", fifo_priv_flag, 2'b00);
            end
            if (icache_req && (halted || used >= BUF_DEPTH)) begin
                other_errors++;
                $display("Error at %0t: cache request made while halted or out of credit", $time);
            end
            if (used >= BUF_DEPTH) begin
                full_cycles++;
            end
            if (fifo_valid && decode_ready && sb_q.size() != 0) begin
                if (sb_q[0].excp == EXCP_ADEF) begin
                    adef_pops++;
                end
                compare_pop(sb_q.pop_front());
                used--;
            end
            if (resp_pend && !flush_now) begin
                sb_q.push_back(exp_entry_t'{resp_addr, EXCP_NONE, priv_level});
            end
            if (adef_now) begin
                sb_q.push_back(exp_entry_t'{bad_target, EXCP_ADEF, priv_level});
                used++;                                // The exception entry takes a slot too
            end
            adef_now   = flush_now && halted;
            resp_pend  = icache_req;
            resp_addr  = exp_fetch;
            cache_req  = icache_req;
            cache_addr = icache_pc;
            if (icache_req) begin
                check_addr("icache_pc", icache_pc, exp_fetch);
                exp_fetch = exp_fetch + 32'd8;
                used++;
            end
            flush_now = redirect;
            if (redirect) begin
                exp_fetch  = redirect_pc;
                bad_target = redirect_pc;
                halted     = redirect_pc[1:0] != 2'b00;
                used       = 0;
            end
            drained = (sb_q.size() == 0) && !fifo_valid && !adef_now && !resp_pend;
        end
    end

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        logic timed_out;
        arst_n       = 1'b0;
        redirect     = 1'b0;
        redirect_pc  = PC_RESET;
        decode_ready = 1'b0;
        priv_level   = 2'd0;
        set_row(0, 24, READY_ALWAYS, 1'b0, 32'h0000_0000, 2'd0);
        set_row(1, 20, READY_NEVER, 1'b0, 32'h0000_0000, 2'd1);
        set_row(2, 24, READY_ALWAYS, 1'b0, 32'h0000_0000, 2'd1);
        set_row(3, 30, READY_RANDOM, 1'b1, 32'h1c00_4000, 2'd3);
        set_row(4, 20, READY_RANDOM, 1'b1, 32'h1c00_8104, 2'd2);
        set_row(5, 3, READY_ALWAYS, 1'b1, 32'h1c00_0200, 2'd0);
        set_row(6, 12, READY_ALWAYS, 1'b1, 32'h1c00_0302, 2'd2);
        set_row(7, 12, READY_ALWAYS, 1'b1, 32'h2000_0010, 2'd1);
        set_row(8, 16, READY_NEVER, 1'b0, 32'h0000_0000, 2'd1);
        set_row(9, 16, READY_RANDOM, 1'b1, 32'h2000_1000, 2'd0);
        set_row(10, 16, READY_ALWAYS, 1'b1, 32'h0000_0001, 2'd3);
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(rows[r]);
        end
        decode_ready <= 1'b1;
        wait_queue_drained(timed_out);
        if (timed_out) begin
            other_errors++;
            $display("Error: the queue did not drain after the last misaligned redirect");
        end
        if (full_cycles == 0 || adef_pops == 0) begin
            other_errors++;
            $display("Error: the queue never filled or no exception entry was popped");
        end
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/fetch_frontend.sv
module fetch_frontend import fetch_pkg::*; #(
    parameter int BUF_DEPTH     = 8,
    parameter int LOG_BUF_DEPTH = 3
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       redirect,
    input  addr_t      redirect_pc,
    output logic       icache_req,
    output addr_t      icache_pc,
    input  logic       icache_resp_valid,
    input  word_t      icache_inst0,
    input  word_t      icache_inst1,
    input  logic       decode_ready,
    input  priv_t      priv_level,
    output logic       fifo_valid,
    output word_t      fifo_inst0,
    output word_t      fifo_inst1,
    output addr_t      fifo_pc,
    output addr_t      fifo_pc_add,
    output addr_t      fifo_pc_next,
    output addr_t      fifo_badv,
    output excp_code_t fifo_exception,
    output priv_t      fifo_priv_flag
);

    logic       push;
    addr_t      push_pc;
    word_t      push_inst0;
    word_t      push_inst1;
    excp_code_t push_excp;
    addr_t      push_badv;
    logic       flush;
    logic       credit_return;                         // One pulse per entry taken by decode

    fetch_ctrl #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_fetch_ctrl (
        .clk               (clk),
        .arst_n            (arst_n),
        .redirect          (redirect),
        .redirect_pc       (redirect_pc),
        .credit_return     (credit_return),
        .icache_resp_valid (icache_resp_valid),
        .icache_inst0      (icache_inst0),
        .icache_inst1      (icache_inst1),
        .icache_req        (icache_req),
        .icache_pc         (icache_pc),
        .push              (push),
        .push_pc           (push_pc),
        .push_inst0        (push_inst0),
        .push_inst1        (push_inst1),
        .push_excp         (push_excp),
        .push_badv         (push_badv),
        .flush             (flush)
    );

    fetch_buffer #(
        .BUF_DEPTH     (BUF_DEPTH),
        .LOG_BUF_DEPTH (LOG_BUF_DEPTH)
    ) u_fetch_buffer (
        .clk            (clk),
        .arst_n         (arst_n),
        .flush          (flush),
        .push           (push),
        .push_pc        (push_pc),
        .push_inst0     (push_inst0),
        .push_inst1     (push_inst1),
        .push_excp      (push_excp),
        .push_badv      (push_badv),
        .priv_level     (priv_level),
        .decode_ready   (decode_ready),
        .credit_return  (credit_return),
        .fifo_valid     (fifo_valid),
        .fifo_inst0     (fifo_inst0),
        .fifo_inst1     (fifo_inst1),
        .fifo_pc        (fifo_pc),
        .fifo_pc_add    (fifo_pc_add),
        .fifo_pc_next   (fifo_pc_next),
        .fifo_badv      (fifo_badv),
        .fifo_exception (fifo_exception),
        .fifo_priv_flag (fifo_priv_flag)
    );

endmodule

//--- verilog/fetch_buffer.sv
module fetch_buffer import fetch_pkg::*; #(
    parameter int BUF_DEPTH     = 8,
    parameter int LOG_BUF_DEPTH = 3
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       flush,
    input  logic       push,
    input  addr_t      push_pc,
    input  word_t      push_inst0,
    input  word_t      push_inst1,
    input  excp_code_t push_excp,
    input  addr_t      push_badv,
    input  priv_t      priv_level,
    input  logic       decode_ready,
    output logic       credit_return,
    output logic       fifo_valid,
    output word_t      fifo_inst0,
    output word_t      fifo_inst1,
    output addr_t      fifo_pc,
    output addr_t      fifo_pc_add,
    output addr_t      fifo_pc_next,
    output addr_t      fifo_badv,
    output excp_code_t fifo_exception,
    output priv_t      fifo_priv_flag
);

    localparam int INST_W = 64;                        // Two instruction words
    localparam int PC_W   = 96;                        // pc_next, pc and badv
    localparam int STAT_W = 9;                         // Privilege and exception code

    logic [INST_W-1:0] inst_din;
    logic [INST_W-1:0] inst_dout;
    logic [PC_W-1:0]   pc_din;
    logic [PC_W-1:0]   pc_dout;
    logic [STAT_W-1:0] stat_din;
    logic [STAT_W-1:0] stat_dout;
    logic              inst_full;
    logic              inst_empty;
    logic              pc_full;
    logic              pc_empty;
    logic              stat_full;
    logic              stat_empty;
    logic              lane_full;
    logic              lane_empty;
    logic              write_en;
    logic              pop_en;

    // The lanes move in lock step, so any one of them tells the state of all
    assign lane_full  = inst_full | pc_full | stat_full;
    assign lane_empty = inst_empty | pc_empty | stat_empty;

    assign write_en = push && !lane_full;

    // Nothing is handed to decode in the cycle the queue is being flushed
    assign fifo_valid    = !lane_empty && !flush;
    assign pop_en        = fifo_valid && decode_ready;
    assign credit_return = pop_en;

    assign inst_din = {push_inst1, push_inst0};
    assign pc_din   = {push_pc + FETCH_STRIDE, push_pc, push_badv};
    assign stat_din = {priv_level, push_excp};     // Privilege is taken at push time

    assign fifo_pc_add = fifo_pc + INST_STEP;

    always_comb begin
        if (fifo_valid) begin
            fifo_inst0     = inst_dout[31:0];
            fifo_inst1     = inst_dout[63:32];
            fifo_pc_next   = pc_dout[95:64];
            fifo_pc        = pc_dout[63:32];
            fifo_badv      = pc_dout[31:0];
            fifo_priv_flag = stat_dout[8:7];
            fifo_exception = stat_dout[6:0];
        end else begin
            fifo_inst0     = INST_NOP;
            fifo_inst1     = INST_NOP;
            fifo_pc_next   = PC_RESET + FETCH_STRIDE;
            fifo_pc        = PC_RESET;
            fifo_badv      = PC_RESET;
            fifo_priv_flag = '0;
            fifo_exception = EXCP_NONE;
        end
    end

    fifo_generator #(
        .DATA_WIDTH    (INST_W),
        .BUF_DEPTH     (BUF_DEPTH),
        .LOG_BUF_DEPTH (LOG_BUF_DEPTH)
    ) inst_lane (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .write_en (write_en),
        .pop_en   (pop_en),
        .din      (inst_din),
        .dout     (inst_dout),
        .full     (inst_full),
        .empty    (inst_empty)
    );

    fifo_generator #(
        .DATA_WIDTH    (PC_W),
        .BUF_DEPTH     (BUF_DEPTH),
        .LOG_BUF_DEPTH (LOG_BUF_DEPTH)
    ) pc_lane (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .write_en (write_en),
        .pop_en   (pop_en),
        .din      (pc_din),
        .dout     (pc_dout),
        .full     (pc_full),
        .empty    (pc_empty)
    );

    fifo_generator #(
        .DATA_WIDTH    (STAT_W),
        .BUF_DEPTH     (BUF_DEPTH),
        .LOG_BUF_DEPTH (LOG_BUF_DEPTH)
    ) stat_lane (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .write_en (write_en),
        .pop_en   (pop_en),
        .din      (stat_din),
        .dout     (stat_dout),
        .full     (stat_full),
        .empty    (stat_empty)
    );

endmodule

//--- verilog/fetch_ctrl.sv
module fetch_ctrl import fetch_pkg::*; #(
    parameter int BUF_DEPTH = 8
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       redirect,
    input  addr_t      redirect_pc,
    input  logic       credit_return,
    input  logic       icache_resp_valid,
    input  word_t      icache_inst0,
    input  word_t      icache_inst1,
    output logic       icache_req,
    output addr_t      icache_pc,
    output logic       push,
    output addr_t      push_pc,
    output word_t      push_inst0,
    output word_t      push_inst1,
    output excp_code_t push_excp,
    output addr_t      push_badv,
    output logic       flush
);

    localparam int                  CREDIT_W   = $clog2(BUF_DEPTH + 1);
    localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(BUF_DEPTH);

    fetch_state_t        state;
    fetch_state_t        next_state;
    addr_t               fetch_pc;
    addr_t               inflight_pc;                  // Address of the request awaiting its words
    logic [CREDIT_W-1:0] credits;
    logic                inflight_vld;
    logic                adef_pend;                    // Bad target seen, entry not yet written
    logic                halted;                       // Exception written, wait for a redirect
    logic                pc_misaligned;
    logic                resp_push;
    logic                excp_push;
    logic                spend;

    assign pc_misaligned = fetch_pc[1:0] != 2'b00;
    assign icache_pc     = fetch_pc;

    // The drain cycle already fetches the new target, unless it is misaligned
    assign icache_req = (credits != '0) &&
                        ((state == FETCH_RUN) || (state == FETCH_DRAIN && !pc_misaligned));

    // Words arriving in the drain cycle answer a request from before the redirect
    assign resp_push = icache_resp_valid && inflight_vld && (state != FETCH_DRAIN);
    assign excp_push = (state == FETCH_IDLE) && adef_pend;
    assign spend     = icache_req || excp_push;    // A bad address still takes a queue slot

    assign push       = resp_push || excp_push;
    assign push_pc    = excp_push ? fetch_pc : inflight_pc;
    assign push_badv  = push_pc;
    assign push_inst0 = excp_push ? INST_NOP : icache_inst0;
    assign push_inst1 = excp_push ? INST_NOP : icache_inst1;
    assign push_excp  = excp_push ? EXCP_ADEF : EXCP_NONE;

    always_comb begin
        next_state = state;
        case (state)
            FETCH_IDLE: begin
                if (!adef_pend && !halted) begin
                    next_state = FETCH_RUN;        // Only the first cycle after reset ends here
                end
            end
            FETCH_DRAIN: next_state = pc_misaligned ? FETCH_IDLE : FETCH_RUN;
            FETCH_RUN:   next_state = FETCH_RUN;
            default:     next_state = FETCH_IDLE;
        endcase
        if (redirect) begin
            next_state = FETCH_DRAIN;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= FETCH_IDLE;
            fetch_pc     <= PC_RESET;
            credits      <= CREDIT_MAX;
            inflight_vld <= 1'b0;
            flush        <= 1'b0;
            adef_pend    <= 1'b0;
            halted       <= 1'b0;
        end else begin
            state        <= next_state;
            flush        <= redirect;                  // Queue is cleared on the following edge
            inflight_vld <= icache_req;
            if (redirect) begin
                fetch_pc  <= redirect_pc;
                credits   <= CREDIT_MAX;               // The whole queue will be free after the flush
                adef_pend <= 1'b0;
                halted    <= 1'b0;
            end else begin
                if (icache_req) begin
                    fetch_pc <= fetch_pc + FETCH_STRIDE;
                end
                if (spend && !credit_return) begin
                    credits <= credits - 1'b1;
                end else if (!spend && credit_return) begin
                    credits <= credits + 1'b1;
                end
                if (state == FETCH_DRAIN && pc_misaligned) begin
                    adef_pend <= 1'b1;                 // Written once the flush has passed
                end
                if (excp_push) begin
                    adef_pend <= 1'b0;
                    halted    <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (icache_req) begin
            inflight_pc <= fetch_pc;
        end
    end

endmodule

//--- verilog/fifo_generator.sv
module fifo_generator #(
    parameter int DATA_WIDTH    = 32,
    parameter int BUF_DEPTH     = 8,
    parameter int LOG_BUF_DEPTH = 3
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,
    input  logic                  write_en,
    input  logic                  pop_en,
    input  logic [DATA_WIDTH-1:0] din,
    output logic [DATA_WIDTH-1:0] dout,
    output logic                  full,
    output logic                  empty
);

    localparam logic [LOG_BUF_DEPTH:0]   FULL_COUNT = (LOG_BUF_DEPTH + 1)'(BUF_DEPTH);
    localparam logic [LOG_BUF_DEPTH-1:0] LAST_PTR   = LOG_BUF_DEPTH'(BUF_DEPTH - 1);

    logic [DATA_WIDTH-1:0]    mem [BUF_DEPTH];
    logic [LOG_BUF_DEPTH-1:0] wr_ptr;
    logic [LOG_BUF_DEPTH-1:0] rd_ptr;
    logic [LOG_BUF_DEPTH:0]   count;                   // One bit wider so a full queue fits
    logic                     do_write;
    logic                     do_read;

    assign full  = count == FULL_COUNT;
    assign empty = count == '0;

    // Requests against a full or empty queue are ignored
    assign do_write = write_en && !full;
    assign do_read  = pop_en && !empty;

    // The head entry is visible on dout without a read cycle
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_write && !flush) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;                              // Flush drops every entry, even one being written
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;               // Simultaneous push and pop keep the level
            endcase
        end
    end

endmodule

//--- verilog/fetch_pkg.sv
package fetch_pkg;

    typedef logic [31:0] word_t;                       // One instruction word
    typedef logic [31:0] addr_t;                       // Fetch address or program counter
    typedef logic [6:0]  excp_code_t;                  // Exception code of a queue entry
    typedef logic [1:0]  priv_t;                       // Privilege level at fetch time

    // Boot vector that is also shown on the decode port while the queue is empty
    localparam addr_t PC_RESET = 32'h1c00_0000;

    // andi r0,r0,0 is the canonical no-op
    localparam word_t INST_NOP = 32'h0340_0000;

    localparam excp_code_t EXCP_NONE = 7'h00;          // Entry carries no exception
    localparam excp_code_t EXCP_ADEF = 7'h08;          // Fetch address error

    localparam addr_t FETCH_STRIDE = 32'd8;            // One aligned pair per fetch
    localparam addr_t INST_STEP    = 32'd4;            // Offset of the second word in a pair

    typedef enum logic [1:0] {
        FETCH_IDLE  = 2'd0,                            // Waiting after reset or after a bad target
        FETCH_RUN   = 2'd1,                            // Sequential fetch while credits last
        FETCH_DRAIN = 2'd2                             // Flush cycle right after a redirect
    } fetch_state_t;

endpackage
